// File: video_frame_writer.f
+incdir+.
vid_pkg.sv
stream_ingress.sv
frame_writer.sv
mem_write_engine.sv
frame_mem.sv
video_frame_writer_top.sv
tb_video_frame_writer.sv

// File: tb_video_frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_wr_config.svh"

module tb_video_frame_writer;

	import vid_pkg::*;

	localparam int LINE_PIX        = 8;   // Test frames are 8 x 4
	localparam int TOTAL_BEATS     = 325; // Stream beats over all tests
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 + 1500;

	logic       clk;
	logic       rst_n;
	frame_len_t pixels_per_frame;
	line_cnt_t  frame_height;
	pixel_t     s_axis_tdata;
	logic       s_axis_tvalid;
	logic       s_axis_tlast;
	logic       s_axis_tuser;
	logic       s_axis_tready;
	mem_addr_t  rd_addr;
	pixel_t     rd_data;
	logic       frame_ready;
	mem_addr_t  frame_base;
	logic       len_error;

	int          cyc = 0;     // Free-running cycle count
	int          last_accept; // Cycle after the most recent accepted beat
	int          final_cycs [$];
	mem_addr_t   ready_bases [$];
	int          ready_cycs [$];
	logic        ready_trdy [$]; // tready seen during each frame_ready pulse
	int unsigned seed;

	video_frame_writer_top u_video_frame_writer_top (
		.clk              (clk),
		.rst_n            (rst_n),
		.pixels_per_frame (pixels_per_frame),
		.frame_height     (frame_height),
		.s_axis_tdata     (s_axis_tdata),
		.s_axis_tvalid    (s_axis_tvalid),
		.s_axis_tlast     (s_axis_tlast),
		.s_axis_tuser     (s_axis_tuser),
		.s_axis_tready    (s_axis_tready),
		.rd_addr          (rd_addr),
		.rd_data          (rd_data),
		.frame_ready      (frame_ready),
		.frame_base       (frame_base),
		.len_error        (len_error)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period

	always @(posedge clk) cyc <= cyc + 1;

	// Log every frame_ready pulse where outputs are settled
	always @(negedge clk) begin
		if (frame_ready) begin
			ready_bases.push_back(frame_base);
			ready_cycs.push_back(cyc);
			ready_trdy.push_back(s_axis_tready);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog timeout");
	end

	// Frame number, line and column packed into one word
	function automatic pixel_t pixel_value(input int f, input int l, input int c);
		return {8'(f), 8'(l), 16'(c)};
	endfunction

	task automatic check_pixel(input string tname, input pixel_t exp, input pixel_t act);
		if (act !== exp) begin
			$display("ERROR %s pixel: expected %h, actual %h", tname, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "pixel mismatch");
		end
	endtask

	task automatic check_addr(input string tname, input mem_addr_t exp, input mem_addr_t act);
		if (act !== exp) begin
			$display("ERROR %s address: expected %h, actual %h", tname, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_flag(input string tname, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERROR %s flag: expected %b, actual %b", tname, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// Presents one beat, returns once tready is seen high for it
	task automatic send_beat(input pixel_t d, input logic sol, input logic eol, input int gap);
		repeat (gap) begin
			@(posedge clk);
			s_axis_tvalid <= 1'b0; // Idle cycles between beats
		end
		@(posedge clk);
		s_axis_tvalid <= 1'b1;
		s_axis_tdata  <= d;
		s_axis_tuser  <= sol;
		s_axis_tlast  <= eol;
		@(negedge clk);
		while (!s_axis_tready)
			@(negedge clk);
		last_accept = cyc + 1; // Taken at the coming edge
	endtask

	task automatic stream_idle();
		@(posedge clk);
		s_axis_tvalid <= 1'b0;
	endtask

	task automatic send_frame(input int f, input int lines, input int max_gap);
		int gap;
		for (int l = 0; l < lines; l++) begin
			for (int c = 0; c < LINE_PIX; c++) begin
				gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
				send_beat(pixel_value(f, l, c), (l == 0 && c == 0), (c == LINE_PIX - 1), gap);
			end
		end
		final_cycs.push_back(last_accept);
	endtask

	// Oldest outstanding frame, bounded by the pipeline latency
	task automatic wait_frame_ready(input string tname, input mem_addr_t exp_base,
		output logic trdy);
		int final_cyc;
		int rdy_cyc;
		final_cyc = final_cycs.pop_front();
		while (ready_bases.size() == 0) begin
			if (cyc - final_cyc > `VW_DELAY_DEPTH + 2) begin
				$display("Test %s: no frame_ready pulse within %0d cycles of the final beat",
					tname, `VW_DELAY_DEPTH + 2);
				$display("SIMULATION FAILED");
				$fatal(1, "frame_ready missing");
			end
			@(negedge clk);
		end
		rdy_cyc = ready_cycs.pop_front();
		trdy    = ready_trdy.pop_front();
		if (rdy_cyc - final_cyc > `VW_DELAY_DEPTH + 2) begin
			$display("Test %s: frame_ready came %0d cycles after the final beat",
				tname, rdy_cyc - final_cyc);
			$display("SIMULATION FAILED");
			$fatal(1, "frame_ready late");
		end
		check_addr(tname, exp_base, ready_bases.pop_front());
	endtask

	task automatic read_word(input mem_addr_t addr, output pixel_t d);
		@(posedge clk);
		rd_addr <= addr;
		@(posedge clk);  // RAM registers the word here
		@(negedge clk);
		d = rd_data;
	endtask

	task automatic read_back_frame(input string tname, input int base, input int f,
		input int lines);
		pixel_t d;
		for (int l = 0; l < lines; l++) begin
			for (int c = 0; c < LINE_PIX; c++) begin
				read_word(mem_addr_t'(base + l * LINE_PIX + c), d);
				check_pixel(tname, pixel_value(f, l, c), d);
			end
		end
	endtask

	task automatic single_frame();
		logic trdy;
		send_frame(0, 4, 0);
		stream_idle();
		wait_frame_ready("single_frame", 12'd0, trdy);
		read_back_frame("single_frame", 0, 0, 4);
		check_flag("single_frame", 1'b0, len_error);
	endtask

	// Buffer 1 is next after the single frame
	task automatic rotation();
		logic trdy;
		mem_addr_t bases [4] = '{12'd32, 12'd64, 12'd0, 12'd32};
		for (int i = 0; i < 4; i++) begin
			send_frame(i + 1, 4, 0);
			stream_idle();
			wait_frame_ready("rotation", bases[i], trdy);
		end
		read_back_frame("rotation", 32, 4, 4); // Overwritten by the fourth frame
		read_back_frame("rotation", 64, 2, 4);
		read_back_frame("rotation", 0, 3, 4);
	endtask

	task automatic pre_sol_discard();
		logic trdy;
		for (int i = 0; i < 5; i++)
			send_beat(32'hBAD0_0000 + pixel_t'(i), 1'b0, (i == 2), 0);
		send_frame(5, 4, 0);
		stream_idle();
		wait_frame_ready("pre_sol_discard", 12'd64, trdy);
		read_back_frame("pre_sol_discard", 64, 5, 4);
	endtask

	task automatic gaps_and_stall();
		logic trdy;
		send_frame(6, 4, 3);  // Random idle gaps
		send_frame(7, 4, 0);  // Back to back, hits the DRAIN window
		stream_idle();
		wait_frame_ready("gaps_and_stall", 12'd0, trdy);
		check_flag("gaps_and_stall", 1'b0, trdy); // Port closed while draining
		wait_frame_ready("gaps_and_stall", 12'd32, trdy);
		read_back_frame("gaps_and_stall", 0, 6, 4);
		read_back_frame("gaps_and_stall", 32, 7, 4);
	endtask

	task automatic length_errors();
		logic   trdy;
		pixel_t d;
		apply_reset();  // Buffer index back to 0
		@(posedge clk);
		frame_height <= 16'd5;
		send_frame(8, 5, 0);
		stream_idle();
		wait_frame_ready("long_frame", 12'd0, trdy);
		check_flag("long_frame", 1'b1, len_error);
		read_back_frame("long_frame", 0, 8, 4);
		// Overrun must not reach buffer 1
		for (int c = 0; c < LINE_PIX; c++) begin
			read_word(mem_addr_t'(32 + c), d);
			check_pixel("long_frame", pixel_value(7, 0, c), d);
		end
		apply_reset();
		check_flag("short_frame", 1'b0, len_error);
		@(posedge clk);
		frame_height <= 16'd3;
		send_frame(9, 3, 0);
		stream_idle();
		wait_frame_ready("short_frame", 12'd0, trdy);
		check_flag("short_frame", 1'b1, len_error);
	endtask

	initial begin
		seed             = $urandom(67245);
		rst_n            = 1'b0;
		pixels_per_frame = 32'd32;
		frame_height     = 16'd4;
		s_axis_tdata     = '0;
		s_axis_tvalid    = 1'b0;
		s_axis_tlast     = 1'b0;
		s_axis_tuser     = 1'b0;
		rd_addr          = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		single_frame();
		rotation();
		pre_sol_discard();
		gaps_and_stall();
		length_errors();

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: video_frame_writer_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_frame_writer_top (
	input  wire                 clk,
	input  wire                 rst_n,
	input  vid_pkg::frame_len_t pixels_per_frame,
	input  vid_pkg::line_cnt_t  frame_height,
	input  vid_pkg::pixel_t     s_axis_tdata,
	input  wire                 s_axis_tvalid,
	input  wire                 s_axis_tlast,
	input  wire                 s_axis_tuser,
	output logic                s_axis_tready,
	input  vid_pkg::mem_addr_t  rd_addr,
	output vid_pkg::pixel_t     rd_data,
	output logic                frame_ready,
	output vid_pkg::mem_addr_t  frame_base,
	output logic                len_error
);

	import vid_pkg::*;

	// Ingress to writer
	logic        pix_valid;
	logic        pix_ready;
	pix_beat_t   pix_beat;

	// Writer to engine
	logic        burst_start;
	burst_desc_t burst_desc;
	logic        beat_valid;
	wr_beat_t    wr_beat;
	logic        burst_done;

	// Engine to memory
	logic        mem_we;
	mem_addr_t   mem_waddr;
	pixel_t      mem_wdata;

	stream_ingress u_ingress (
		.clk           (clk),
		.rst_n         (rst_n),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tready (s_axis_tready),
		.pix_valid     (pix_valid),
		.pix_beat      (pix_beat),
		.pix_ready     (pix_ready)
	);

	frame_writer u_writer (
		.clk              (clk),
		.rst_n            (rst_n),
		.pixels_per_frame (pixels_per_frame),
		.frame_height     (frame_height),
		.pix_valid        (pix_valid),
		.pix_beat         (pix_beat),
		.pix_ready        (pix_ready),
		.burst_start      (burst_start),
		.burst_desc       (burst_desc),
		.beat_valid       (beat_valid),
		.wr_beat          (wr_beat),
		.burst_done       (burst_done),
		.frame_ready      (frame_ready),
		.frame_base       (frame_base)
	);

	mem_write_engine u_engine (
		.clk         (clk),
		.rst_n       (rst_n),
		.burst_start (burst_start),
		.burst_desc  (burst_desc),
		.beat_valid  (beat_valid),
		.wr_beat     (wr_beat),
		.burst_done  (burst_done),
		.len_error   (len_error),
		.mem_we      (mem_we),
		.mem_waddr   (mem_waddr),
		.mem_wdata   (mem_wdata)
	);

	frame_mem u_mem (
		.clk       (clk),
		.mem_we    (mem_we),
		.mem_waddr (mem_waddr),
		.mem_wdata (mem_wdata),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

endmodule

`default_nettype wire

// File: frame_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_wr_config.svh"

module frame_mem (
	input  wire                clk,
	input  wire                mem_we,
	input  vid_pkg::mem_addr_t mem_waddr,
	input  vid_pkg::pixel_t    mem_wdata,
	input  vid_pkg::mem_addr_t rd_addr,
	output vid_pkg::pixel_t    rd_data
);

	import vid_pkg::*;

	// All buffers share one array
	pixel_t mem [2**`VW_ADDR_BITS];

	// Write port
	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_waddr] <= mem_wdata;
	end

	// Registered read, one cycle latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// File: mem_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module mem_write_engine (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  burst_start,
	input  vid_pkg::burst_desc_t burst_desc,
	input  wire                  beat_valid,
	input  vid_pkg::wr_beat_t    wr_beat,
	output logic                 burst_done,
	output logic                 len_error,  // Sticky until reset
	output logic                 mem_we,
	output vid_pkg::mem_addr_t   mem_waddr,
	output vid_pkg::pixel_t      mem_wdata
);

	import vid_pkg::*;

	engine_state_t state;

	mem_addr_t  burst_base; // Latched descriptor
	frame_len_t burst_len;
	frame_len_t beat_cnt;   // Beats seen in this burst
	frame_len_t cnt_next;
	logic       in_range;   // Still inside the buffer

	assign cnt_next = beat_cnt + 32'd1;
	assign in_range = (beat_cnt < burst_len);

	// Write in the same cycle as the beat, overruns dropped
	assign mem_we    = (state == E_WRITE) && beat_valid && in_range;
	assign mem_waddr = burst_base + mem_addr_t'(beat_cnt);
	assign mem_wdata = wr_beat.data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= E_IDLE;
			beat_cnt   <= '0;
			burst_done <= 1'b0;
			len_error  <= 1'b0;
		end else begin
			burst_done <= 1'b0;
			case (state)
				E_IDLE: begin
					if (burst_start) begin
						state    <= E_WRITE;
						beat_cnt <= '0;
					end
				end
				E_WRITE: begin
					if (beat_valid) begin
						beat_cnt <= cnt_next;
						if (wr_beat.frame_last) begin
							state      <= E_IDLE;
							burst_done <= 1'b1;
							if (cnt_next != burst_len)
								len_error <= 1'b1; // Frame longer or shorter than len
						end
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	// Descriptor payload
	always_ff @(posedge clk) begin
		if (burst_start && state == E_IDLE) begin
			burst_base <= burst_desc.base;
			burst_len  <= burst_desc.len;
		end
	end

	// Writer delay line must keep descriptor ahead of beats
	a_no_beat_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		beat_valid |-> state == E_WRITE
	) else $error("mem_write_engine: beat arrived with no burst open");

endmodule

`default_nettype wire

// File: frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_wr_config.svh"

module frame_writer (
	input  wire                 clk,
	input  wire                 rst_n,
	input  vid_pkg::frame_len_t pixels_per_frame,
	input  vid_pkg::line_cnt_t  frame_height,
	input  wire                 pix_valid,
	input  vid_pkg::pix_beat_t  pix_beat,
	output logic                pix_ready,
	output logic                burst_start,
	output vid_pkg::burst_desc_t burst_desc,
	output logic                beat_valid,
	output vid_pkg::wr_beat_t   wr_beat,
	input  wire                 burst_done,
	output logic                frame_ready,
	output vid_pkg::mem_addr_t  frame_base
);

	import vid_pkg::*;

	writer_state_t state, next_state;

	buf_idx_t   buf_idx;    // Buffer being filled next
	line_cnt_t  line_cnt;   // Lines finished in current frame
	line_cnt_t  line_base;
	frame_len_t base_full;  // pixels_per_frame * buf_idx
	logic       take;
	logic       start;
	logic       in_frame;   // Accepted beat belongs to the frame
	logic       frame_end;  // Beat that closes the last line
	logic       last_buf;

	// Delay line toward the engine
	logic [`VW_DELAY_DEPTH-1:0] dly_valid;
	wr_beat_t                   dly_beat [`VW_DELAY_DEPTH];

	assign pix_ready = (state != DRAIN); // Closed from final tlast until burst_done
	assign take      = pix_valid && pix_ready;
	assign start     = (state == IDLE) && take && pix_beat.sol;
	assign in_frame  = start || ((state == RECEIVE) && take);
	assign line_base = (state == IDLE) ? '0 : line_cnt; // Fresh count on sol
	assign frame_end = in_frame && pix_beat.eol &&
		(line_cnt_t'(line_base + 16'd1) == frame_height);
	assign last_buf  = (buf_idx == buf_idx_t'(`VW_NUM_BUFFERS - 1));

	// Descriptor for the buffer about to be filled
	assign base_full       = pixels_per_frame * frame_len_t'(buf_idx);
	assign burst_start     = start;
	assign burst_desc.base = mem_addr_t'(base_full);
	assign burst_desc.len  = pixels_per_frame;

	assign beat_valid = dly_valid[`VW_DELAY_DEPTH-1];
	assign wr_beat    = dly_beat[`VW_DELAY_DEPTH-1];

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (start)
					next_state = frame_end ? DRAIN : RECEIVE; // One-line frames possible
			end
			RECEIVE: begin
				if (frame_end)
					next_state = DRAIN;
			end
			DRAIN: begin
				if (burst_done)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= IDLE;
			buf_idx     <= '0;
			line_cnt    <= '0;
			frame_ready <= 1'b0;
			frame_base  <= '0;
			dly_valid   <= '0;
		end else begin
			state       <= next_state;
			frame_ready <= 1'b0;
			dly_valid   <= {dly_valid[`VW_DELAY_DEPTH-2:0], in_frame};

			if (in_frame)
				line_cnt <= pix_beat.eol ? line_cnt_t'(line_base + 16'd1) : line_base;

			if (start)
				frame_base <= burst_desc.base; // Reported when frame completes

			// Frame fully written, report and rotate
			if (state == DRAIN && burst_done) begin
				frame_ready <= 1'b1;
				buf_idx     <= last_buf ? '0 : buf_idx + 2'd1;
			end
		end
	end

	// Beat data through the delay line
	always_ff @(posedge clk) begin
		dly_beat[0] <= '{data: pix_beat.data, frame_last: frame_end};
		for (int i = 1; i < `VW_DELAY_DEPTH; i++)
			dly_beat[i] <= dly_beat[i-1];
	end

	// New burst only once the previous frame has left the delay line
	a_start_pipe_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		burst_start |-> (dly_valid == '0)
	) else $error("frame_writer: burst_start with beats of the previous frame in flight");

	a_buf_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		buf_idx < buf_idx_t'(`VW_NUM_BUFFERS)
	) else $error("frame_writer: buffer index out of range");

endmodule

`default_nettype wire

// File: stream_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module stream_ingress (
	input  wire               clk,
	input  wire               rst_n,
	input  vid_pkg::pixel_t   s_axis_tdata,
	input  wire               s_axis_tvalid,
	input  wire               s_axis_tlast,  // End of line
	input  wire               s_axis_tuser,  // Start of frame
	output logic              s_axis_tready,
	output logic              pix_valid,
	output vid_pkg::pix_beat_t pix_beat,
	input  wire               pix_ready
);

	import vid_pkg::*;

	pix_beat_t in_beat;
	pix_beat_t skid_beat;  // Holds one beat caught while output stalls
	logic      skid_valid;
	logic      accept;
	logic      out_free;   // Main register may load this cycle

	assign in_beat  = '{data: s_axis_tdata, sol: s_axis_tuser, eol: s_axis_tlast};
	assign accept   = s_axis_tvalid && s_axis_tready;
	assign out_free = !pix_valid || pix_ready;

	// Control flops, tready comes straight from a register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_valid     <= 1'b0;
			skid_valid    <= 1'b0;
			s_axis_tready <= 1'b0;
		end else if (out_free) begin
			if (skid_valid)
				pix_valid <= 1'b1; // Skid beat moves forward
			else
				pix_valid <= accept;
			skid_valid    <= 1'b0;
			s_axis_tready <= 1'b1;
		end else if (accept) begin
			// Output stalled, park the beat and close the port
			skid_valid    <= 1'b1;
			s_axis_tready <= 1'b0;
		end else begin
			s_axis_tready <= !skid_valid;
		end
	end

	// Payload, no reset needed
	always_ff @(posedge clk) begin
		if (out_free)
			pix_beat <= skid_valid ? skid_beat : in_beat;
		if (accept && !out_free)
			skid_beat <= in_beat;
	end

	// Held beat must not change until taken
	a_hold_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_beat)
	) else $error("stream_ingress: pix_beat changed while stalled");

endmodule

`default_nettype wire

// File: vid_pkg.sv
`default_nettype none

`include "vid_wr_config.svh"

package vid_pkg;

	// One pixel word
	typedef logic [`VW_PIXEL_BITS-1:0] pixel_t;
	typedef logic [`VW_ADDR_BITS-1:0]  mem_addr_t;  // Frame memory word address
	typedef logic [15:0]               line_cnt_t;  // Lines, frame height
	typedef logic [31:0]               frame_len_t; // Pixels per frame
	typedef logic [1:0]                buf_idx_t;   // 0 to 2

	// Beat from ingress to frame writer
	typedef struct packed {
		pixel_t data;
		logic   sol; // tuser, start of frame
		logic   eol; // tlast, end of line
	} pix_beat_t;

	// Beat from frame writer to write engine
	typedef struct packed {
		pixel_t data;
		logic   frame_last; // Final pixel of the frame
	} wr_beat_t;

	// Burst descriptor, issued once per frame
	typedef struct packed {
		mem_addr_t  base;
		frame_len_t len;
	} burst_desc_t;

	typedef enum logic [1:0] {
		IDLE,    // Waiting for sol
		RECEIVE, // Frame in progress
		DRAIN    // Last beat in flight, waiting for burst_done
	} writer_state_t;

	typedef enum logic {
		E_IDLE,
		E_WRITE
	} engine_state_t;

endpackage

`default_nettype wire

// File: vid_wr_config.svh
`ifndef VID_WR_CONFIG_SVH
`define VID_WR_CONFIG_SVH

// Pixel word width on the stream and in frame memory
`define VW_PIXEL_BITS 32

// Word address into frame memory, 4K words
`define VW_ADDR_BITS 12

// Rotating frame buffers
`define VW_NUM_BUFFERS 3

// Stages between pixel acceptance and the write engine
`define VW_DELAY_DEPTH 3

`endif
